// ==== source/rf_defs.svh ====
// Register file sizing.
// Word width, register count and port counts shared by every block of the core.

`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// Width of one register and of every datapath word.
`define RF_DATA_W 16

// Number of architectural registers.
`define RF_REGS 16

// Register address width.
`define RF_ADDR_W 4

// Two operand reads plus the debug read.
`define RF_RD_PORTS 3

// Writeback from the execute unit plus the external load.
`define RF_WR_PORTS 2

`endif

// ==== source/isa_pkg.sv ====
// Instruction set definitions.
// Opcodes and the two 16-bit instruction formats, overlaid as one packed union.

`include "rf_defs.svh"

package isa_pkg;

   localparam int unsigned IMM_W = 8;

   // Codes 7 to 15 are no-ops and produce no result.
   typedef enum logic [3:0]
   {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_XOR  = 4'h4,
      OP_ADDI = 4'h5,
      OP_LI   = 4'h6
   } opcode_e;

   typedef struct packed
   {
      opcode_e                opcode;
      logic [`RF_ADDR_W-1:0]  rd;
      logic [`RF_ADDR_W-1:0]  rs1;
      logic [`RF_ADDR_W-1:0]  rs2;
   } r_fmt_t;

   typedef struct packed
   {
      opcode_e                opcode;
      logic [`RF_ADDR_W-1:0]  rd;
      logic [IMM_W-1:0]       imm;
   } i_fmt_t;

   // The opcode and rd fields sit at the same bits in both views.
   typedef union packed
   {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
   } instr_u;

endpackage

// ==== source/exec_pkg.sv ====
// Execute stage types and helpers.
// The writeback request and the ALU functions used by the execute unit.

`include "rf_defs.svh"

package exec_pkg;

   typedef struct packed
   {
      logic                   v;
      logic [`RF_ADDR_W-1:0]  addr;
      logic [`RF_DATA_W-1:0]  data;
   } wb_req_t;

   // True for every opcode that writes a register.
   function automatic logic has_result(isa_pkg::opcode_e op);
      case (op)
         isa_pkg::OP_ADD,
         isa_pkg::OP_SUB,
         isa_pkg::OP_AND,
         isa_pkg::OP_OR,
         isa_pkg::OP_XOR,
         isa_pkg::OP_ADDI,
         isa_pkg::OP_LI:  return 1'b1;
         default:         return 1'b0;
      endcase
   endfunction

   function automatic logic [`RF_DATA_W-1:0] sext_imm(logic [isa_pkg::IMM_W-1:0] imm);
      return {{(`RF_DATA_W - isa_pkg::IMM_W){imm[isa_pkg::IMM_W-1]}}, imm};
   endfunction

   function automatic logic [`RF_DATA_W-1:0] zext_imm(logic [isa_pkg::IMM_W-1:0] imm);
      return {{(`RF_DATA_W - isa_pkg::IMM_W){1'b0}}, imm};
   endfunction

   // The immediate forms arrive with the extended immediate already on b.
   function automatic logic [`RF_DATA_W-1:0] alu_result(isa_pkg::opcode_e op,
                                                        logic [`RF_DATA_W-1:0] a,
                                                        logic [`RF_DATA_W-1:0] b);
      case (op)
         isa_pkg::OP_ADD,
         isa_pkg::OP_ADDI: return a + b;
         isa_pkg::OP_SUB:  return a - b;
         isa_pkg::OP_AND:  return a & b;
         isa_pkg::OP_OR:   return a | b;
         isa_pkg::OP_XOR:  return a ^ b;
         isa_pkg::OP_LI:   return b;
         default:          return '0;
      endcase
   endfunction

endpackage

// ==== source/rf_read_if.sv ====
// Operand read interface.
// Two asynchronous read ports, a and b, from the execute unit to the register file.

`include "rf_defs.svh"

interface rf_read_if;

   logic                   a_v;
   logic [`RF_ADDR_W-1:0]  a_addr;
   logic [`RF_DATA_W-1:0]  a_data;

   logic                   b_v;
   logic [`RF_ADDR_W-1:0]  b_addr;
   logic [`RF_DATA_W-1:0]  b_data;

   // The requester drives valids and addresses and gets data back in the same cycle.
   modport requester
   (
      output a_v, a_addr, b_v, b_addr,
      input  a_data, b_data
   );

   modport responder
   (
      input  a_v, a_addr, b_v, b_addr,
      output a_data, b_data
   );

endinterface

// ==== source/reg_mem_multiport.sv ====
// Multiport RAM.
// N asynchronous read ports and M synchronous write ports over one storage array.
// Writes are applied in port order, so a higher port overrides a lower one.

module reg_mem_multiport
#(
   parameter int unsigned width_p                 = 16,
   parameter int unsigned els_p                   = 16,
   parameter int unsigned read_ports_p            = 2,
   parameter int unsigned write_ports_p           = 1,
   parameter bit          write_write_same_addr_p = 1'b0,
   localparam int unsigned addr_width_lp          = (els_p > 1) ? $clog2(els_p) : 1
)
(
   input  logic                                       w_clk_i,
   input  logic                                       rst_i,

   input  logic [write_ports_p-1:0]                   w_v_i,
   input  logic [write_ports_p-1:0][addr_width_lp-1:0] w_addr_i,
   input  logic [write_ports_p-1:0][width_p-1:0]      w_data_i,

   input  logic [read_ports_p-1:0]                    r_v_i,
   input  logic [read_ports_p-1:0][addr_width_lp-1:0] r_addr_i,
   output logic [read_ports_p-1:0][width_p-1:0]       r_data_o
);

   logic [width_p-1:0]       mem [els_p];
   logic [write_ports_p-1:0] w_en;

   // Every read port returns its entry whatever its read valid says.
   for (genvar i = 0; i < read_ports_p; i++)
   begin : g_rd
      assign r_data_o[i] = mem[r_addr_i[i]];
   end

   // When same-address writes are not allowed, a colliding write is dropped on
   // every port involved instead of leaving the entry to port order.
   always_comb
   begin
      for (int i = 0; i < write_ports_p; i++)
      begin
         w_en[i] = w_v_i[i] & ~rst_i;
      end
      if (!write_write_same_addr_p)
      begin
         for (int i = 0; i < write_ports_p; i++)
         begin
            for (int j = 0; j < write_ports_p; j++)
            begin
               if ((i != j) && w_v_i[i] && w_v_i[j] && (w_addr_i[i] == w_addr_i[j]))
               begin
                  w_en[i] = 1'b0;
               end
            end
         end
      end
   end

   always_ff @(posedge w_clk_i)
   begin
      for (int i = 0; i < write_ports_p; i++)
      begin
         if (w_en[i])
         begin
            mem[w_addr_i[i]] <= w_data_i[i];
         end
      end
   end

endmodule

// ==== source/exec_unit.sv ====
// Execute unit.
// Decodes one instruction per cycle, reads two operands with writeback forwarding,
// runs the ALU and holds the result in a one-entry writeback register.

`include "rf_defs.svh"

module exec_unit
(
   input  logic              w_clk_i,
   input  logic              rst_i,

   input  logic              instr_v_i,
   input  isa_pkg::instr_u   instr_i,

   rf_read_if.requester      rd_if,

   output exec_pkg::wb_req_t wb_o
);

   isa_pkg::opcode_e             op;
   logic                         imm_form;
   logic [`RF_ADDR_W-1:0]        dst_addr;
   logic [`RF_ADDR_W-1:0]        src_a_addr;
   logic [`RF_ADDR_W-1:0]        src_b_addr;
   logic [isa_pkg::IMM_W-1:0]    imm;

   logic                         fwd_a;
   logic                         fwd_b;
   logic [`RF_DATA_W-1:0]        opnd_a;
   logic [`RF_DATA_W-1:0]        opnd_b_reg;
   logic [`RF_DATA_W-1:0]        opnd_b;
   logic [`RF_DATA_W-1:0]        result;
   logic                         result_v;

   logic                         wb_v_q;
   logic [`RF_ADDR_W-1:0]        wb_addr_q;
   logic [`RF_DATA_W-1:0]        wb_data_q;

   // Opcode and rd overlap in both formats, so either view gives the same bits.
   assign op       = instr_i.r_fmt.opcode;
   assign dst_addr = instr_i.r_fmt.rd;
   assign imm      = instr_i.i_fmt.imm;

   always_comb
   begin
      case (op)
         isa_pkg::OP_ADDI,
         isa_pkg::OP_LI: imm_form = 1'b1;
         default:        imm_form = 1'b0;
      endcase
   end

   // ADDI reads its own destination as the first source.
   assign src_a_addr = imm_form ? instr_i.i_fmt.rd : instr_i.r_fmt.rs1;
   assign src_b_addr = instr_i.r_fmt.rs2;

   assign rd_if.a_v    = instr_v_i;
   assign rd_if.a_addr = src_a_addr;
   assign rd_if.b_v    = instr_v_i & ~imm_form;
   assign rd_if.b_addr = src_b_addr;

   // The pending writeback is the newest value of its register until the
   // clock edge that commits it, so it takes precedence over the array.
   assign fwd_a = wb_v_q && (wb_addr_q == src_a_addr);
   assign fwd_b = wb_v_q && (wb_addr_q == src_b_addr);

   assign opnd_a     = fwd_a ? wb_data_q : rd_if.a_data;
   assign opnd_b_reg = fwd_b ? wb_data_q : rd_if.b_data;

   always_comb
   begin
      case (op)
         isa_pkg::OP_ADDI: opnd_b = exec_pkg::sext_imm(imm);
         isa_pkg::OP_LI:   opnd_b = exec_pkg::zext_imm(imm);
         default:          opnd_b = opnd_b_reg;
      endcase
   end

   assign result   = exec_pkg::alu_result(op, opnd_a, opnd_b);
   assign result_v = instr_v_i & exec_pkg::has_result(op);

   always_ff @(posedge w_clk_i)
   begin
      if (rst_i)
      begin
         wb_v_q <= 1'b0;
      end
      else
      begin
         wb_v_q <= result_v;
      end
   end

   always_ff @(posedge w_clk_i)
   begin
      if (result_v)
      begin
         wb_addr_q <= dst_addr;
         wb_data_q <= result;
      end
   end

   assign wb_o.v    = wb_v_q;
   assign wb_o.addr = wb_addr_q;
   assign wb_o.data = wb_data_q;

endmodule

// ==== source/regfile_core_top.sv ====
// Register file core.
// Connects the execute unit to a 3-read, 2-write register file. Port 0 takes
// writeback, port 1 the external load, and read port 2 serves debug.

`include "rf_defs.svh"

module regfile_core_top
(
   input  logic                                w_clk_i,
   input  logic                                rst_i,

   input  logic                                instr_v_i,
   input  logic [$bits(isa_pkg::instr_u)-1:0]  instr_i,

   input  logic                                load_v_i,
   input  logic [`RF_ADDR_W-1:0]               load_addr_i,
   input  logic [`RF_DATA_W-1:0]               load_data_i,

   input  logic [`RF_ADDR_W-1:0]               dbg_addr_i,
   output logic [`RF_DATA_W-1:0]               dbg_data_o,

   output logic                                result_v_o,
   output logic [`RF_ADDR_W-1:0]               result_addr_o,
   output logic [`RF_DATA_W-1:0]               result_data_o
);

   isa_pkg::instr_u     instr;
   exec_pkg::wb_req_t   wb;

   logic [`RF_WR_PORTS-1:0]                   w_v;
   logic [`RF_WR_PORTS-1:0][`RF_ADDR_W-1:0]   w_addr;
   logic [`RF_WR_PORTS-1:0][`RF_DATA_W-1:0]   w_data;
   logic [`RF_RD_PORTS-1:0]                   r_v;
   logic [`RF_RD_PORTS-1:0][`RF_ADDR_W-1:0]   r_addr;
   logic [`RF_RD_PORTS-1:0][`RF_DATA_W-1:0]   r_data;

   rf_read_if rd_if ();

   assign instr = isa_pkg::instr_u'(instr_i);

   exec_unit i_exec
   (
      .w_clk_i   (w_clk_i),
      .rst_i     (rst_i),
      .instr_v_i (instr_v_i),
      .instr_i   (instr),
      .rd_if     (rd_if.requester),
      .wb_o      (wb)
   );

   // The load sits on the higher port so it beats writeback to the same register.
   assign w_v    = {load_v_i, wb.v};
   assign w_addr = {load_addr_i, wb.addr};
   assign w_data = {load_data_i, wb.data};

   // Responder side of the operand interface maps onto read ports 0 and 1.
   assign r_v    = {1'b1, rd_if.b_v, rd_if.a_v};
   assign r_addr = {dbg_addr_i, rd_if.b_addr, rd_if.a_addr};

   assign rd_if.a_data = r_data[0];
   assign rd_if.b_data = r_data[1];
   assign dbg_data_o   = r_data[2];

   reg_mem_multiport
   #(
      .width_p                 (`RF_DATA_W),
      .els_p                   (`RF_REGS),
      .read_ports_p            (`RF_RD_PORTS),
      .write_ports_p           (`RF_WR_PORTS),
      .write_write_same_addr_p (1'b1)
   )
   i_rf
   (
      .w_clk_i  (w_clk_i),
      .rst_i    (rst_i),
      .w_v_i    (w_v),
      .w_addr_i (w_addr),
      .w_data_i (w_data),
      .r_v_i    (r_v),
      .r_addr_i (r_addr),
      .r_data_o (r_data)
   );

   assign result_v_o    = wb.v;
   assign result_addr_o = wb.addr;
   assign result_data_o = wb.data;

endmodule

// ==== dv/regfile_core_checker.sv ====
// Register file core checker.
// Concurrent assertions on result timing, bound to the core top level.

module regfile_core_checker
(
   input logic        w_clk_i,
   input logic        rst_i,
   input logic        instr_v_i,
   input logic [15:0] instr_i,
   input logic        result_v_o
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_cnt = 0;
   logic        known_op;

   // Opcodes 0 to 6 are the ones that write a register.
   assign known_op = (instr_i[15:12] <= 4'd6);

   a_quiet_in_reset : assert property (@(posedge w_clk_i)
      rst_i && $past(rst_i) |-> !result_v_o)
   else
   begin
      $error("result_v_o is high during reset");
      fail_cnt++;
   end

   a_result_follows_instr : assert property (@(posedge w_clk_i) disable iff (rst_i)
      instr_v_i && known_op |=> result_v_o)
   else
   begin
      $error("a valid instruction with a known opcode gave no result");
      fail_cnt++;
   end

   a_no_spurious_result : assert property (@(posedge w_clk_i) disable iff (rst_i)
      result_v_o |-> $past(instr_v_i))
   else
   begin
      $error("result_v_o is high without an instruction in the previous cycle");
      fail_cnt++;
   end

endmodule

bind regfile_core_top regfile_core_checker i_checker
(
   .w_clk_i    (w_clk_i),
   .rst_i      (rst_i),
   .instr_v_i  (instr_v_i),
   .instr_i    (instr_i),
   .result_v_o (result_v_o)
);

// ==== dv/regfile_core_tb.sv ====
// Register file core testbench.
// Drives loads and instructions, keeps a register model and checks results
// and debug reads against it.

module regfile_core_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned RESET_CYCLES = 16;
   localparam int unsigned T1_CYCLES    = 33;
   localparam int unsigned T2_CYCLES    = 64;
   localparam int unsigned T3_CYCLES    = 16;
   localparam int unsigned T4_CYCLES    = 16;
   localparam int unsigned T5_CYCLES    = 8;
   localparam int unsigned T6_CYCLES    = 26;
   localparam int unsigned MARGIN       = 200;
   localparam int unsigned WDOG_CYCLES  = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                          + T4_CYCLES + T5_CYCLES + T6_CYCLES + MARGIN;

   logic        w_clk_i = 1'b0;
   logic        rst_i;
   logic        instr_v_i;
   logic [15:0] instr_i;
   logic        load_v_i;
   logic [3:0]  load_addr_i;
   logic [15:0] load_data_i;
   logic [3:0]  dbg_addr_i;
   logic [15:0] dbg_data_o;
   logic        result_v_o;
   logic [3:0]  result_addr_o;
   logic [15:0] result_data_o;

   logic [15:0] model [16];
   logic        exp_v;
   logic [3:0]  exp_addr;
   logic [15:0] exp_data;
   logic [31:0] rng = 32'h442c_7b4e;

   string       cur_test;
   int unsigned test_errors;
   int unsigned tests_run;
   int unsigned tests_failed;

   always #20 w_clk_i = ~w_clk_i;

   regfile_core_top i_dut
   (
      .w_clk_i       (w_clk_i),
      .rst_i         (rst_i),
      .instr_v_i     (instr_v_i),
      .instr_i       (instr_i),
      .load_v_i      (load_v_i),
      .load_addr_i   (load_addr_i),
      .load_data_i   (load_data_i),
      .dbg_addr_i    (dbg_addr_i),
      .dbg_data_o    (dbg_data_o),
      .result_v_o    (result_v_o),
      .result_addr_o (result_addr_o),
      .result_data_o (result_data_o)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [15:0] r_instr(input logic [3:0] op, input logic [3:0] rd,
                                           input logic [3:0] rs1, input logic [3:0] rs2);
      return {op, rd, rs1, rs2};
   endfunction

   function automatic logic [15:0] i_instr(input logic [3:0] op, input logic [3:0] rd,
                                           input logic [7:0] imm);
      return {op, rd, imm};
   endfunction

   task automatic check_value(input string what, input logic [15:0] exp,
                              input logic [15:0] act);
      assert (act === exp)
      else
      begin
         $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_result();
      check_value("result_v", {15'd0, exp_v}, {15'd0, result_v_o});
      if (exp_v)
      begin
         check_value("result_addr", {12'd0, exp_addr}, {12'd0, result_addr_o});
         check_value("result_data", exp_data, result_data_o);
      end
   endtask

   // One clock cycle. The instruction reads the model before the load of the
   // same cycle lands, and its own result becomes visible to the next one.
   task automatic cycle(input logic iv, input logic [15:0] ins, input logic lv,
                        input logic [3:0] la, input logic [15:0] ld);
      logic [3:0]  op;
      logic [3:0]  rd;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] d;
      logic        v;
      check_result();
      op = ins[15:12];
      rd = ins[11:8];
      a  = model[ins[7:4]];
      b  = model[ins[3:0]];
      v  = iv;
      case (op)
         4'd0:    d = a + b;
         4'd1:    d = a - b;
         4'd2:    d = a & b;
         4'd3:    d = a | b;
         4'd4:    d = a ^ b;
         4'd5:    d = model[rd] + {{8{ins[7]}}, ins[7:0]};
         4'd6:    d = {8'h00, ins[7:0]};
         default:
         begin
            d = 16'h0000;
            v = 1'b0;
         end
      endcase
      if (v)
      begin
         model[rd] = d;
      end
      if (lv)
      begin
         model[la] = ld;
      end
      instr_v_i   = iv;
      instr_i     = ins;
      load_v_i    = lv;
      load_addr_i = la;
      load_data_i = ld;
      @(posedge w_clk_i);
      #2;
      exp_v    = v;
      exp_addr = rd;
      exp_data = d;
   endtask

   task automatic idle();
      cycle(1'b0, 16'h0000, 1'b0, 4'h0, 16'h0000);
   endtask

   // One debug read per cycle while no instruction or load is presented.
   task automatic check_debug(input logic [3:0] addr);
      dbg_addr_i = addr;
      #1;
      check_value($sformatf("dbg r%0d", addr), model[addr], dbg_data_o);
      @(posedge w_clk_i);
      #2;
   endtask

   task automatic begin_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors != 0)
      begin
         tests_failed++;
      end
      $display("test %s: %s (%0d errors)", cur_test, (test_errors == 0) ? "PASS" : "FAIL",
               test_errors);
   endtask

   initial
   begin
      #(WDOG_CYCLES * 40);
      $display("Watchdog expired before the tests finished");
      $display("Test failures found");
      $finish;
   end

   initial
   begin
      int unsigned checker_fails;
      logic [3:0]  r;
      rst_i       = 1'b1;
      // A valid instruction during reset must not produce a result.
      instr_v_i   = 1'b1;
      instr_i     = i_instr(isa_pkg::OP_LI, 4'h0, 8'h55);
      load_v_i    = 1'b0;
      load_addr_i = 4'h0;
      load_data_i = 16'h0000;
      dbg_addr_i  = 4'h0;
      exp_v       = 1'b0;
      exp_addr    = 4'h0;
      exp_data    = 16'h0000;
      tests_run    = 0;
      tests_failed = 0;
      repeat (RESET_CYCLES - 1) @(posedge w_clk_i);
      #2;
      instr_v_i = 1'b0;
      @(posedge w_clk_i);
      #2;
      rst_i = 1'b0;

      begin_test("load_and_debug");
      for (int i = 0; i < 16; i++)
      begin
         rng = xorshift(rng);
         cycle(1'b0, 16'h0000, 1'b1, i[3:0], rng[15:0]);
      end
      idle();
      for (int i = 0; i < 16; i++)
      begin
         check_debug(i[3:0]);
      end
      end_test();

      begin_test("register_ops");
      for (int i = 0; i < 30; i++)
      begin
         rng = xorshift(rng);
         cycle(1'b1, r_instr(rng[18:16] % 3'd5, rng[11:8], rng[7:4], rng[3:0]),
               1'b0, 4'h0, 16'h0000);
         idle();
      end
      end_test();

      begin_test("immediates");
      cycle(1'b1, i_instr(isa_pkg::OP_ADDI, 4'h3, 8'hf0), 1'b0, 4'h0, 16'h0000);
      idle();
      cycle(1'b1, i_instr(isa_pkg::OP_ADDI, 4'h4, 8'h7f), 1'b0, 4'h0, 16'h0000);
      idle();
      cycle(1'b1, i_instr(isa_pkg::OP_ADDI, 4'h5, 8'h80), 1'b0, 4'h0, 16'h0000);
      idle();
      cycle(1'b1, i_instr(isa_pkg::OP_LI, 4'h6, 8'hc3), 1'b0, 4'h0, 16'h0000);
      idle();
      cycle(1'b1, i_instr(isa_pkg::OP_LI, 4'h7, 8'h5a), 1'b0, 4'h0, 16'h0000);
      idle();
      end_test();

      begin_test("forwarding");
      cycle(1'b1, i_instr(isa_pkg::OP_LI, 4'h1, 8'h21), 1'b0, 4'h0, 16'h0000);
      cycle(1'b1, r_instr(isa_pkg::OP_ADD, 4'h2, 4'h1, 4'h1), 1'b0, 4'h0, 16'h0000);
      cycle(1'b1, r_instr(isa_pkg::OP_SUB, 4'h3, 4'h9, 4'h2), 1'b0, 4'h0, 16'h0000);
      cycle(1'b1, r_instr(isa_pkg::OP_XOR, 4'h3, 4'h3, 4'h3), 1'b0, 4'h0, 16'h0000);
      cycle(1'b1, i_instr(isa_pkg::OP_ADDI, 4'h3, 8'hfe), 1'b0, 4'h0, 16'h0000);
      cycle(1'b1, r_instr(isa_pkg::OP_OR, 4'h4, 4'h3, 4'h2), 1'b0, 4'h0, 16'h0000);
      idle();
      for (int i = 1; i < 5; i++)
      begin
         check_debug(i[3:0]);
      end
      end_test();

      begin_test("load_collisions");
      cycle(1'b1, r_instr(isa_pkg::OP_ADD, 4'h8, 4'ha, 4'hb), 1'b1, 4'ha, 16'hbeef);
      cycle(1'b1, r_instr(isa_pkg::OP_AND, 4'hc, 4'hd, 4'he), 1'b0, 4'h0, 16'h0000);
      cycle(1'b0, 16'h0000, 1'b1, 4'hc, 16'h1234);
      idle();
      check_debug(4'h8);
      check_debug(4'ha);
      check_debug(4'hc);
      end_test();

      begin_test("unknown_opcodes");
      for (int i = 7; i < 16; i++)
      begin
         rng = xorshift(rng);
         cycle(1'b1, {i[3:0], rng[11:0]}, 1'b0, 4'h0, 16'h0000);
      end
      idle();
      for (int i = 0; i < 16; i++)
      begin
         r = i[3:0];
         check_debug(r);
      end
      end_test();

      checker_fails = i_dut.i_checker.fail_cnt;
      $display("Tests run: %0d, failed: %0d, assertion failures: %0d", tests_run,
               tests_failed, checker_fails);
      if ((tests_failed == 0) && (checker_fails == 0))
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+source
source/isa_pkg.sv
source/exec_pkg.sv
source/rf_read_if.sv
source/reg_mem_multiport.sv
source/exec_unit.sv
source/regfile_core_top.sv
dv/regfile_core_checker.sv
dv/regfile_core_tb.sv

// ==== Makefile ====
SRCS := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vregfile_core_tb: list.f $(SRCS)
	verilator --binary --assert --timing -f list.f --top-module regfile_core_tb -Mdir obj_dir

run: obj_dir/Vregfile_core_tb
	./obj_dir/Vregfile_core_tb | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
